// ==== include/cache_bank_cfg.svh ====
`ifndef CACHE_BANK_CFG_SVH
`define CACHE_BANK_CFG_SVH

// Bank geometry
`define CB_WAYS      4
`define CB_SETS      4
`define CB_ADDR_W    15
`define CB_LINE_W    128
`define CB_WORD_W    32
`define CB_WAY_W     2
`define CB_AGE_W     2

// Physical address fields
`define CB_OFFSET_W  4
`define CB_WSEL_LSB  2
`define CB_WSEL_W    2
`define CB_INDEX_LSB 4
`define CB_INDEX_W   2
`define CB_TAG_LSB   6
`define CB_TAG_W     9

`endif

// ==== hdl/cache_bank_pkg.sv ====
`include "cache_bank_cfg.svh"

package cache_bank_pkg;

    // Byte address, {tag, index, word, byte}
    typedef logic [`CB_ADDR_W-1:0] addr_t;

    typedef logic [`CB_TAG_W-1:0] tag_t;
    typedef logic [`CB_INDEX_W-1:0] index_t;
    typedef logic [`CB_WSEL_W-1:0] word_sel_t;

    typedef logic [`CB_WAY_W-1:0] way_t;
    typedef logic [`CB_WAYS-1:0] way_mask_t;

    typedef logic [`CB_WORD_W-1:0] word_t;

    // Word 0 in the low bits
    typedef logic [`CB_LINE_W-1:0] line_t;

    // 0 is most recently used
    typedef logic [`CB_AGE_W-1:0] age_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_DONE,
        FILL_REQ,
        FILL_DONE,
        ACCESS,
        RESP
    } ctrl_state_t;

endpackage

// ==== hdl/tag_store.sv ====
`include "cache_bank_cfg.svh"

module tag_store (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cache_bank_pkg::index_t    index,
    input  cache_bank_pkg::tag_t      tag_in,
    input  cache_bank_pkg::way_mask_t valid_bits,
    input  logic                      tag_wr,
    input  cache_bank_pkg::way_t      wr_way,
    output logic                      hit,
    output cache_bank_pkg::way_t      hit_way,
    input  cache_bank_pkg::way_t      victim_way,
    output cache_bank_pkg::tag_t      victim_tag
);

    cache_bank_pkg::tag_t      tags_q [`CB_SETS][`CB_WAYS];
    cache_bank_pkg::way_mask_t match;

    // Compare all ways of the set in parallel
    always_comb begin
        for (int w = 0; w < `CB_WAYS; w++) begin
            match[w] = valid_bits[w] && (tags_q[index][w] == tag_in);
        end
    end

    assign hit = |match;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (match[w]) begin
                hit_way = cache_bank_pkg::way_t'(w);
            end
        end
    end

    // Tag of the line about to be evicted
    assign victim_tag = tags_q[index][victim_way];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `CB_SETS; s++) begin
                for (int w = 0; w < `CB_WAYS; w++) begin
                    tags_q[s][w] <= '0;
                end
            end
        end else if (tag_wr) begin
            tags_q[index][wr_way] <= tag_in;
        end
    end

endmodule

// ==== hdl/line_store.sv ====
`include "cache_bank_cfg.svh"

module line_store (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cache_bank_pkg::index_t    index,
    input  cache_bank_pkg::word_sel_t word_sel,
    input  cache_bank_pkg::way_t      rd_way,
    input  cache_bank_pkg::way_t      wr_way,
    input  logic                      word_wr,
    input  cache_bank_pkg::word_t     wr_word,
    input  logic                      line_fill,
    input  cache_bank_pkg::line_t     fill_line,
    output cache_bank_pkg::word_t     rd_word,
    output cache_bank_pkg::line_t     victim_line
);

    cache_bank_pkg::line_t lines_q [`CB_SETS][`CB_WAYS];
    cache_bank_pkg::line_t hit_line;

    assign hit_line = lines_q[index][rd_way];
    assign rd_word  = hit_line[word_sel*`CB_WORD_W +: `CB_WORD_W];

    // The write way doubles as the victim during a miss
    assign victim_line = lines_q[index][wr_way];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `CB_SETS; s++) begin
                for (int w = 0; w < `CB_WAYS; w++) begin
                    lines_q[s][w] <= '0;
                end
            end
        end else if (line_fill) begin
            lines_q[index][wr_way] <= fill_line;
        end else if (word_wr) begin
            // Merge one store word into the line
            lines_q[index][wr_way][word_sel*`CB_WORD_W +: `CB_WORD_W] <= wr_word;
        end
    end

endmodule

// ==== hdl/replace_state.sv ====
`include "cache_bank_cfg.svh"

module replace_state (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cache_bank_pkg::index_t    index,
    input  logic                      touch,
    input  cache_bank_pkg::way_t      touch_way,
    input  logic                      mark_valid,
    input  logic                      mark_dirty,
    output cache_bank_pkg::way_mask_t valid_bits,
    output cache_bank_pkg::way_t      victim_way,
    output logic                      victim_dirty
);

    cache_bank_pkg::way_mask_t valid_q [`CB_SETS];
    cache_bank_pkg::way_mask_t dirty_q [`CB_SETS];
    cache_bank_pkg::age_t      age_q   [`CB_SETS][`CB_WAYS];
    cache_bank_pkg::age_t      used_age;
    cache_bank_pkg::age_t      oldest_age;

    assign valid_bits   = valid_q[index];
    assign used_age     = age_q[index][touch_way];
    assign victim_dirty = dirty_q[index][victim_way];

    // Oldest way wins, lowest index on a tie; any invalid way overrides
    always_comb begin
        victim_way = '0;
        oldest_age = age_q[index][0];
        for (int w = 1; w < `CB_WAYS; w++) begin
            if (age_q[index][w] > oldest_age) begin
                oldest_age = age_q[index][w];
                victim_way = cache_bank_pkg::way_t'(w);
            end
        end
        for (int w = `CB_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[index][w]) begin
                victim_way = cache_bank_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `CB_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < `CB_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else begin
            // Fresh line from memory is clean
            if (mark_valid) begin
                valid_q[index][touch_way] <= 1'b1;
                dirty_q[index][touch_way] <= 1'b0;
            end
            if (mark_dirty) begin
                dirty_q[index][touch_way] <= 1'b1;
            end
            // Equal ages only occur among untouched ways after reset
            if (touch) begin
                for (int w = 0; w < `CB_WAYS; w++) begin
                    if (cache_bank_pkg::way_t'(w) == touch_way) begin
                        age_q[index][w] <= '0;
                    end else if (age_q[index][w] <= used_age) begin
                        age_q[index][w] <= age_q[index][w] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/bank_ctrl.sv ====
`include "cache_bank_cfg.svh"

module bank_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      req,
    input  logic                      we,
    input  cache_bank_pkg::addr_t     addr,
    input  cache_bank_pkg::word_t     wdata,
    input  logic                      hit,
    input  cache_bank_pkg::way_t      hit_way,
    input  cache_bank_pkg::way_t      victim_way,
    input  logic                      victim_dirty,
    input  cache_bank_pkg::tag_t      victim_tag,
    input  cache_bank_pkg::line_t     victim_line,
    input  logic                      mem_ack,
    input  cache_bank_pkg::line_t     mem_rdata,
    input  cache_bank_pkg::word_t     rd_word,
    output logic                      ack,
    output cache_bank_pkg::word_t     rdata,
    output cache_bank_pkg::index_t    index,
    output cache_bank_pkg::word_sel_t word_sel,
    output logic                      tag_wr,
    output logic                      line_fill,
    output logic                      word_wr,
    output cache_bank_pkg::way_t      wr_way,
    output cache_bank_pkg::line_t     fill_line,
    output cache_bank_pkg::word_t     wr_word,
    output logic                      mark_valid,
    output logic                      mark_dirty,
    output logic                      touch,
    output logic                      mem_req,
    output logic                      mem_we,
    output cache_bank_pkg::addr_t     mem_addr,
    output cache_bank_pkg::line_t     mem_wdata
);

    cache_bank_pkg::ctrl_state_t state_q;
    cache_bank_pkg::ctrl_state_t state_nxt;
    cache_bank_pkg::addr_t       addr_q;
    cache_bank_pkg::word_t       wdata_q;
    cache_bank_pkg::way_t        victim_q;
    logic                        we_q;
    logic                        do_access;
    logic                        fill_now;

    assign index    = addr_q[`CB_INDEX_LSB +: `CB_INDEX_W];
    assign word_sel = addr_q[`CB_WSEL_LSB +: `CB_WSEL_W];
    assign wr_word  = wdata_q;

    // Hit in LOOKUP, or the replay once the line is in
    assign do_access = (state_q == cache_bank_pkg::LOOKUP && hit) ||
                       (state_q == cache_bank_pkg::ACCESS);
    assign fill_now  = (state_q == cache_bank_pkg::FILL_REQ) && mem_ack;

    assign wr_way     = (state_q == cache_bank_pkg::LOOKUP) ? hit_way : victim_q;
    assign word_wr    = do_access && we_q;
    assign mark_dirty = do_access && we_q;
    assign touch      = do_access;

    // Line goes straight into the store on the first mem_ack cycle
    assign tag_wr     = fill_now;
    assign line_fill  = fill_now;
    assign mark_valid = fill_now;
    assign fill_line  = mem_rdata;

    assign mem_req   = (state_q == cache_bank_pkg::WB_REQ) ||
                       (state_q == cache_bank_pkg::FILL_REQ);
    assign mem_we    = (state_q == cache_bank_pkg::WB_REQ);
    assign mem_wdata = victim_line;
    assign mem_addr  = (state_q == cache_bank_pkg::WB_REQ) ?
                       {victim_tag, index, {`CB_OFFSET_W{1'b0}}} :
                       {addr_q[`CB_TAG_LSB +: `CB_TAG_W], index, {`CB_OFFSET_W{1'b0}}};

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            cache_bank_pkg::IDLE: begin
                if (req) begin
                    state_nxt = cache_bank_pkg::LOOKUP;
                end
            end
            cache_bank_pkg::LOOKUP: begin
                if (hit) begin
                    state_nxt = cache_bank_pkg::RESP;
                end else if (victim_dirty) begin
                    state_nxt = cache_bank_pkg::WB_REQ;
                end else begin
                    state_nxt = cache_bank_pkg::FILL_REQ;
                end
            end
            cache_bank_pkg::WB_REQ: begin
                if (mem_ack) begin
                    state_nxt = cache_bank_pkg::WB_DONE;
                end
            end
            cache_bank_pkg::WB_DONE: begin
                if (!mem_ack) begin
                    state_nxt = cache_bank_pkg::FILL_REQ;
                end
            end
            cache_bank_pkg::FILL_REQ: begin
                if (mem_ack) begin
                    state_nxt = cache_bank_pkg::FILL_DONE;
                end
            end
            cache_bank_pkg::FILL_DONE: begin
                if (!mem_ack) begin
                    state_nxt = cache_bank_pkg::ACCESS;
                end
            end
            cache_bank_pkg::ACCESS: begin
                state_nxt = cache_bank_pkg::RESP;
            end
            cache_bank_pkg::RESP: begin
                if (!req) begin
                    state_nxt = cache_bank_pkg::IDLE;
                end
            end
            default: begin
                state_nxt = cache_bank_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= cache_bank_pkg::IDLE;
            ack     <= 1'b0;
        end else begin
            state_q <= state_nxt;
            if (do_access) begin
                ack <= 1'b1;
            end else if (state_q == cache_bank_pkg::RESP && !req) begin
                ack <= 1'b0;
            end
        end
    end

    // Request and miss bookkeeping
    always_ff @(posedge clk) begin
        if (state_q == cache_bank_pkg::IDLE && req) begin
            addr_q  <= addr;
            we_q    <= we;
            wdata_q <= wdata;
        end
        if (state_q == cache_bank_pkg::LOOKUP && !hit) begin
            victim_q <= victim_way;
        end
        if (do_access) begin
            rdata <= rd_word;
        end
    end

endmodule

// ==== hdl/cache_bank.sv ====
`include "cache_bank_cfg.svh"

module cache_bank (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req,
    input  logic                  we,
    input  cache_bank_pkg::addr_t addr,
    input  cache_bank_pkg::word_t wdata,
    output logic                  ack,
    output cache_bank_pkg::word_t rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output cache_bank_pkg::addr_t mem_addr,
    output cache_bank_pkg::line_t mem_wdata,
    input  logic                  mem_ack,
    input  cache_bank_pkg::line_t mem_rdata
);

    cache_bank_pkg::index_t    index;
    cache_bank_pkg::word_sel_t word_sel;
    cache_bank_pkg::way_t      wr_way;
    cache_bank_pkg::way_t      hit_way;
    cache_bank_pkg::way_t      victim_way;
    cache_bank_pkg::way_mask_t valid_bits;
    cache_bank_pkg::tag_t      victim_tag;
    cache_bank_pkg::line_t     victim_line;
    cache_bank_pkg::line_t     fill_line;
    cache_bank_pkg::word_t     wr_word;
    cache_bank_pkg::word_t     rd_word;
    logic                      hit;
    logic                      victim_dirty;
    logic                      tag_wr;
    logic                      line_fill;
    logic                      word_wr;
    logic                      mark_valid;
    logic                      mark_dirty;
    logic                      touch;

    bank_ctrl ctrl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .rd_word      (rd_word),
        .ack          (ack),
        .rdata        (rdata),
        .index        (index),
        .word_sel     (word_sel),
        .tag_wr       (tag_wr),
        .line_fill    (line_fill),
        .word_wr      (word_wr),
        .wr_way       (wr_way),
        .fill_line    (fill_line),
        .wr_word      (wr_word),
        .mark_valid   (mark_valid),
        .mark_dirty   (mark_dirty),
        .touch        (touch),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    // Requester holds addr stable until ack, so the tag comes from the port
    tag_store tags_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (index),
        .tag_in     (addr[`CB_TAG_LSB +: `CB_TAG_W]),
        .valid_bits (valid_bits),
        .tag_wr     (tag_wr),
        .wr_way     (wr_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .victim_tag (victim_tag)
    );

    line_store lines_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .index       (index),
        .word_sel    (word_sel),
        .rd_way      (hit_way),
        .wr_way      (wr_way),
        .word_wr     (word_wr),
        .wr_word     (wr_word),
        .line_fill   (line_fill),
        .fill_line   (fill_line),
        .rd_word     (rd_word),
        .victim_line (victim_line)
    );

    replace_state repl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .index        (index),
        .touch        (touch),
        .touch_way    (wr_way),
        .mark_valid   (mark_valid),
        .mark_dirty   (mark_dirty),
        .valid_bits   (valid_bits),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

endmodule

// ==== verification/clk_rst_gen.sv ====
module clk_rst_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for five rising edges
    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

// ==== verification/cache_bank_tb.sv ====
`include "cache_bank_cfg.svh"

module cache_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int random_accesses = 40;
    localparam int watchdog_cycles = 200 * random_accesses;
    localparam int delay_slots = 64;

    logic                  clk;
    logic                  arst_n;
    logic                  req;
    logic                  we;
    cache_bank_pkg::addr_t addr;
    cache_bank_pkg::word_t wdata;
    logic                  ack;
    cache_bank_pkg::word_t rdata;
    logic                  mem_req;
    logic                  mem_we;
    cache_bank_pkg::addr_t mem_addr;
    cache_bank_pkg::line_t mem_wdata;
    logic                  mem_ack;
    cache_bank_pkg::line_t mem_rdata;

    // Memory model contents and the log of every request it saw
    cache_bank_pkg::line_t mem_lines [cache_bank_pkg::addr_t];
    int                    mem_delays [delay_slots];
    logic                  log_we [$];
    cache_bank_pkg::addr_t log_addr [$];
    cache_bank_pkg::line_t log_line [$];

    // Reference model of memory and cache
    cache_bank_pkg::line_t ref_mem [cache_bank_pkg::addr_t];
    cache_bank_pkg::tag_t  ref_tag [`CB_SETS][`CB_WAYS];
    cache_bank_pkg::line_t ref_line [`CB_SETS][`CB_WAYS];
    cache_bank_pkg::age_t  ref_age [`CB_SETS][`CB_WAYS];
    logic                  ref_valid [`CB_SETS][`CB_WAYS];
    logic                  ref_dirty [`CB_SETS][`CB_WAYS];

    clk_rst_gen clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    cache_bank dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input cache_bank_pkg::word_t exp,
                              input cache_bank_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input cache_bank_pkg::addr_t exp,
                              input cache_bank_pkg::addr_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input cache_bank_pkg::line_t exp,
                              input cache_bank_pkg::line_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Initial memory data, every word built from the line address
    function automatic cache_bank_pkg::line_t init_line(input cache_bank_pkg::addr_t line_addr);
        cache_bank_pkg::line_t line;
        for (int w = 0; w < `CB_LINE_W / `CB_WORD_W; w++) begin
            line[w*`CB_WORD_W +: `CB_WORD_W] = {line_addr, 2'(w), ~line_addr};
        end
        return line;
    endfunction

    // First invalid way, else the oldest way with the lowest number
    function automatic cache_bank_pkg::way_t pick_victim(input cache_bank_pkg::index_t set);
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (!ref_valid[set][w]) begin
                return cache_bank_pkg::way_t'(w);
            end
        end
        for (int a = `CB_WAYS - 1; a >= 0; a--) begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                if (ref_age[set][w] == cache_bank_pkg::age_t'(a)) begin
                    return cache_bank_pkg::way_t'(w);
                end
            end
        end
        return '0;
    endfunction

    task automatic age_ways(input cache_bank_pkg::index_t set, input cache_bank_pkg::way_t way);
        cache_bank_pkg::age_t used;
        used = ref_age[set][way];
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (w == way) begin
                ref_age[set][w] = '0;
            end else if (ref_age[set][w] <= used) begin
                ref_age[set][w] = ref_age[set][w] + 1'b1;
            end
        end
    endtask

    // One load or store through the full handshake, checked against the model
    task automatic run_access(input logic is_store, input cache_bank_pkg::addr_t a,
                              input cache_bank_pkg::word_t data);
        cache_bank_pkg::index_t    set;
        cache_bank_pkg::tag_t      tag;
        cache_bank_pkg::word_sel_t sel;
        cache_bank_pkg::way_t      way;
        cache_bank_pkg::addr_t     line_addr;
        cache_bank_pkg::addr_t     wb_addr;
        cache_bank_pkg::word_t     exp_rdata;
        logic                      hit;
        int                        cycles;
        logic                      exp_we [$];
        cache_bank_pkg::addr_t     exp_addr [$];
        cache_bank_pkg::line_t     exp_line [$];

        set = a[`CB_INDEX_LSB +: `CB_INDEX_W];
        tag = a[`CB_TAG_LSB +: `CB_TAG_W];
        sel = a[`CB_WSEL_LSB +: `CB_WSEL_W];
        line_addr = {tag, set, {`CB_OFFSET_W{1'b0}}};
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < `CB_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit = 1'b1;
                way = cache_bank_pkg::way_t'(w);
            end
        end
        if (!hit) begin
            way = pick_victim(set);
            if (ref_valid[set][way] && ref_dirty[set][way]) begin
                wb_addr = {ref_tag[set][way], set, {`CB_OFFSET_W{1'b0}}};
                exp_we.push_back(1'b1);
                exp_addr.push_back(wb_addr);
                exp_line.push_back(ref_line[set][way]);
                ref_mem[wb_addr] = ref_line[set][way];
            end
            exp_we.push_back(1'b0);
            exp_addr.push_back(line_addr);
            exp_line.push_back('0);
            ref_line[set][way] = ref_mem.exists(line_addr) ? ref_mem[line_addr] :
                                 init_line(line_addr);
            ref_tag[set][way] = tag;
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = 1'b0;
        end
        exp_rdata = ref_line[set][way][sel*`CB_WORD_W +: `CB_WORD_W];
        if (is_store) begin
            ref_line[set][way][sel*`CB_WORD_W +: `CB_WORD_W] = data;
            ref_dirty[set][way] = 1'b1;
        end
        age_ways(set, way);

        log_we.delete();
        log_addr.delete();
        log_line.delete();
        req = 1'b1;
        we = is_store;
        addr = a;
        wdata = data;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ack);

        if (hit) begin
            check_count("hit latency", 2, cycles);
        end
        if (!is_store) begin
            check_word("rdata", exp_rdata, rdata);
        end
        check_count("memory requests", exp_we.size(), log_we.size());
        for (int i = 0; i < exp_we.size(); i++) begin
            check_flag("mem_we", exp_we[i], log_we[i]);
            check_addr("mem_addr", exp_addr[i], log_addr[i]);
            if (exp_we[i]) begin
                check_line("mem_wdata", exp_line[i], log_line[i]);
            end
        end

        req = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (ack);
        check_count("ack release", 1, cycles);
    endtask

    task automatic test_reset();
        check_flag("ack", 1'b0, ack);
        check_flag("mem_req", 1'b0, mem_req);
    endtask

    task automatic test_cold_load();
        run_access(1'b0, 15'h0048, '0);
        check_count("memory requests", 1, log_we.size());
        check_flag("mem_we", 1'b0, log_we[0]);
        check_addr("mem_addr", 15'h0040, log_addr[0]);
    endtask

    task automatic test_hit_load();
        run_access(1'b0, 15'h0044, '0);
        check_count("memory requests", 0, log_we.size());
    endtask

    task automatic test_store_load();
        run_access(1'b1, 15'h0048, 32'hcafe_0001);
        run_access(1'b0, 15'h0048, '0);
        check_word("rdata", 32'hcafe_0001, rdata);
        check_count("memory requests", 0, log_we.size());
    endtask

    // Five tags into set 2, the fifth evicts the first
    task automatic test_eviction();
        cache_bank_pkg::addr_t first;
        cache_bank_pkg::line_t exp_wb;
        int                    wb_count;
        first = {9'h010, 2'd2, 2'd1, 2'b00};
        for (int i = 0; i < 5; i++) begin
            run_access(1'b1, {9'(9'h010 + i), 2'd2, 2'd1, 2'b00}, 32'h5000_0000 + i);
        end
        wb_count = 0;
        foreach (log_we[i]) begin
            if (log_we[i]) begin
                wb_count++;
            end
        end
        check_count("writebacks", 1, wb_count);
        exp_wb = init_line({9'h010, 2'd2, 4'h0});
        exp_wb[1*`CB_WORD_W +: `CB_WORD_W] = 32'h5000_0000;
        check_flag("mem_we", 1'b1, log_we[0]);
        check_addr("writeback mem_addr", {9'h010, 2'd2, 4'h0}, log_addr[0]);
        check_line("writeback mem_wdata", exp_wb, log_line[0]);
        run_access(1'b0, first, '0);
        check_word("refetched rdata", 32'h5000_0000, rdata);
    endtask

    task automatic test_random();
        cache_bank_pkg::tag_t      tag;
        cache_bank_pkg::index_t    set;
        cache_bank_pkg::word_sel_t sel;
        for (int i = 0; i < random_accesses; i++) begin
            tag = 9'($urandom % 6);
            set = 2'($urandom % 2);
            sel = 2'($urandom % 4);
            run_access(1'($urandom % 2), {tag, set, sel, 2'b00}, $urandom);
        end
    endtask

    // Memory side of the four-phase handshake
    initial begin
        int delay_idx;
        int delay;
        mem_ack = 1'b0;
        mem_rdata = '0;
        delay_idx = 0;
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (mem_ack && !mem_req) begin
                mem_ack = 1'b0;
            end else if (!mem_ack && mem_req) begin
                log_we.push_back(mem_we);
                log_addr.push_back(mem_addr);
                log_line.push_back(mem_wdata);
                delay = mem_delays[delay_idx % delay_slots];
                delay_idx++;
                repeat (delay) @(posedge clk);
                #1;
                if (!mem_req) begin
                    $display("Memory request was dropped before mem_ack at %0t", $time);
                    abort_run();
                end else begin
                    if (mem_we) begin
                        mem_lines[mem_addr] = mem_wdata;
                    end else begin
                        mem_rdata = mem_lines.exists(mem_addr) ? mem_lines[mem_addr] :
                                    init_line(mem_addr);
                    end
                    mem_ack = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Test timed out after %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin
        req = 1'b0;
        we = 1'b0;
        addr = '0;
        wdata = '0;
        void'($urandom(66));
        for (int i = 0; i < delay_slots; i++) begin
            mem_delays[i] = 1 + $urandom % 4;
        end
        for (int s = 0; s < `CB_SETS; s++) begin
            for (int w = 0; w < `CB_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_age[s][w] = '0;
                ref_tag[s][w] = '0;
                ref_line[s][w] = '0;
            end
        end
        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;
        test_reset();
        test_cold_load();
        test_hit_load();
        test_store_load();
        test_eviction();
        test_random();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== cache_bank.f ====
+incdir+include
hdl/cache_bank_pkg.sv
hdl/tag_store.sv
hdl/line_store.sv
hdl/replace_state.sv
hdl/bank_ctrl.sv
hdl/cache_bank.sv
verification/clk_rst_gen.sv
verification/cache_bank_tb.sv

// ==== Bender.yml ====
package:
  name: cache_bank

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/cache_bank_pkg.sv
      - hdl/tag_store.sv
      - hdl/line_store.sv
      - hdl/replace_state.sv
      - hdl/bank_ctrl.sv
      - hdl/cache_bank.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/clk_rst_gen.sv
      - verification/cache_bank_tb.sv
